/* sources.f */
src/mips_isa_pkg.sv
src/decode_pkg.sv
src/kind_decode.sv
src/ctrl_gen.sv
src/operand_resolve.sv
src/instr_decoder.sv
sim/instr_decoder_sva.sv
sim/tb_instr_decoder.sv

/* sim/tb_instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_instr_decoder;

	import mips_isa_pkg::*;
	import decode_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int LATENCY_LIMIT = 10;
	localparam int DRAIN_LIMIT = 10;
	localparam int N_OPERAND = 400;
	localparam int N_RANDOM_RI = 200;
	localparam int N_STALL = 600;
	localparam int MODE_KEPT = 0;
	localparam int MODE_RANDOM = 1;
	localparam int MODE_MIXED = 2;

	// major opcodes other than R_TYPE and REGIMM with their kinds in the same order
	localparam int N_OPS = 22;
	localparam logic [N_OPS*6-1:0] OP_CODES = {
		6'h02, 6'h03, 6'h04, 6'h05, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c,
		6'h0d, 6'h0e, 6'h0f, 6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b
	};
	localparam logic [N_OPS*6-1:0] OP_KINDS = {
		KIND_J, KIND_JAL, KIND_BEQ, KIND_BNE, KIND_BLEZ, KIND_BGTZ, KIND_ADDI,
		KIND_ADDIU, KIND_SLTI, KIND_SLTIU, KIND_ANDI, KIND_ORI, KIND_XORI, KIND_LUI,
		KIND_LB, KIND_LH, KIND_LW, KIND_LBU, KIND_LHU, KIND_SB, KIND_SH, KIND_SW
	};

	localparam int N_FN = 28;
	localparam logic [N_FN*6-1:0] FN_CODES = {
		6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h08, 6'h09, 6'h0a, 6'h0b,
		6'h10, 6'h11, 6'h12, 6'h13, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h20, 6'h21,
		6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b
	};
	localparam logic [N_FN*6-1:0] FN_KINDS = {
		KIND_SLL, KIND_SRL, KIND_SRA, KIND_SLLV, KIND_SRLV, KIND_SRAV, KIND_JR,
		KIND_JALR, KIND_MOVZ, KIND_MOVN, KIND_MFHI, KIND_MTHI, KIND_MFLO, KIND_MTLO,
		KIND_MULT, KIND_MULTU, KIND_DIV, KIND_DIVU, KIND_ADD, KIND_ADDU, KIND_SUB,
		KIND_SUBU, KIND_AND, KIND_OR, KIND_XOR, KIND_NOR, KIND_SLT, KIND_SLTU
	};

	localparam int N_RI = 4;
	localparam logic [N_RI*5-1:0] RI_CODES = {5'h00, 5'h01, 5'h10, 5'h11};
	localparam logic [N_RI*6-1:0] RI_KINDS = {KIND_BLTZ, KIND_BGEZ, KIND_BLTZAL, KIND_BGEZAL};

	// cop0, special2, special3, syscall, break, traps, unaligned and linked memory
	localparam int N_DROP = 17;
	localparam logic [N_DROP*32-1:0] DROPPED = {
		32'h4080_0000, 32'h4000_0000, 32'h4200_0018, 32'h7000_0002, 32'h7000_0020,
		32'h7000_0000, 32'h7c00_0420, 32'h7c00_0000, 32'h0000_000c, 32'h0000_000d,
		32'h0000_0034, 32'h040c_0000, 32'h8800_0000, 32'h9800_0000, 32'hc000_0000,
		32'ha800_0000, 32'hb800_0000
	};

	localparam int SWEEP_CYCLES = N_OPS + 2 * N_FN + N_RI;
	localparam int TOTAL_CYCLES = RESET_CYCLES + LATENCY_LIMIT + 2 + SWEEP_CYCLES
		+ N_OPERAND + N_DROP + N_RANDOM_RI + N_STALL + 5 * (DRAIN_LIMIT + 1);

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	instr_t      instr;
	logic        stall;
	logic        out_valid;
	decoded_t    dut_out;

	logic [31:0] lfsr;
	decoded_t    expected_q[$];
	decoded_t    expected;
	int          errors;
	int          checks;
	int          base_errors;
	int          base_checks;
	int          assert_failures_seen;
	logic        held;
	logic        held_valid;
	decoded_t    held_out;

	instr_decoder dut_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.instr     (instr),
		.stall     (stall),
		.out_valid (out_valid),
		.out       (dut_out)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'ha300_0000;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] r;
		int          b;
		r = '0;
		for (b = 0; b < n; b++) begin
			r = {r[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return r;
	endfunction

	function automatic logic [31:0] kept_word();
		logic [31:0] w;
		int          sel;
		int          idx;
		w = rand_bits(32);
		sel = rand_bits(5);
		if (sel < N_OPS) begin
			w[31:26] = OP_CODES[sel*6 +: 6];
		end else if (sel < 29) begin
			idx = rand_bits(5) % N_FN;
			w[31:26] = 6'h00;
			w[5:0] = FN_CODES[idx*6 +: 6];
		end else begin
			idx = rand_bits(2);
			w[31:26] = 6'h01;
			w[20:16] = RI_CODES[idx*5 +: 5];
		end
		return w;
	endfunction

	function automatic inst_kind_t model_kind(logic [31:0] w);
		inst_kind_t k;
		int         i;
		k = KIND_RESERVED;
		if (w[31:26] == 6'h00) begin
			for (i = 0; i < N_FN; i++) begin
				if (w[5:0] == FN_CODES[i*6 +: 6])
					k = inst_kind_t'(FN_KINDS[i*6 +: 6]);
			end
			if (k == KIND_SRL && w[21])
				k = KIND_ROTR;
			if (k == KIND_SRLV && w[6])
				k = KIND_ROTRV;
		end else if (w[31:26] == 6'h01) begin
			for (i = 0; i < N_RI; i++) begin
				if (w[20:16] == RI_CODES[i*5 +: 5])
					k = inst_kind_t'(RI_KINDS[i*6 +: 6]);
			end
		end else begin
			for (i = 0; i < N_OPS; i++) begin
				if (w[31:26] == OP_CODES[i*6 +: 6])
					k = inst_kind_t'(OP_KINDS[i*6 +: 6]);
			end
		end
		return k;
	endfunction

	function automatic ctrl_t model_ctrl(inst_kind_t k);
		ctrl_t c;
		logic  two_src;
		logic  by_shamt;
		logic  imm_op;
		logic  load;
		logic  store;
		logic  muldiv;
		logic  rs_only;
		c = '0;
		two_src = 1'b0;
		by_shamt = 1'b0;
		imm_op = 1'b0;
		load = 1'b0;
		store = 1'b0;
		muldiv = 1'b0;
		rs_only = 1'b0;
		if (k == KIND_RESERVED) begin
			c.ri = 1'b1;
			return c;
		end
		case (k)
			KIND_ADD, KIND_ADDU, KIND_SUB, KIND_SUBU, KIND_SLT, KIND_SLTU, KIND_AND,
			KIND_OR, KIND_XOR, KIND_NOR, KIND_SLLV, KIND_SRLV, KIND_SRAV, KIND_ROTRV,
			KIND_MOVN, KIND_MOVZ: two_src = 1'b1;
			KIND_SLL, KIND_SRL, KIND_SRA, KIND_ROTR: by_shamt = 1'b1;
			KIND_ADDI, KIND_ADDIU, KIND_SLTI, KIND_SLTIU, KIND_ANDI, KIND_ORI,
			KIND_XORI, KIND_LUI: imm_op = 1'b1;
			KIND_LW, KIND_LB, KIND_LBU, KIND_LH, KIND_LHU: load = 1'b1;
			KIND_SW, KIND_SB, KIND_SH: store = 1'b1;
			KIND_MULT, KIND_MULTU, KIND_DIV, KIND_DIVU: muldiv = 1'b1;
			KIND_JR, KIND_JALR, KIND_MTHI, KIND_MTLO, KIND_BLEZ, KIND_BGTZ, KIND_BLTZ,
			KIND_BGEZ, KIND_BLTZAL, KIND_BGEZAL: rs_only = 1'b1;
			default: ;
		endcase
		c.sign_ex = !(k == KIND_ANDI || k == KIND_ORI || k == KIND_XORI || k == KIND_LUI);
		// dest_sel defaults to rd
		c.regwrite = two_src || by_shamt || k == KIND_MFHI || k == KIND_MFLO;
		if (imm_op || load) begin
			c.regwrite = 1'b1;
			c.dest_sel = DEST_RT;
			c.is_imm = 1'b1;
		end
		if (store) begin
			c.is_imm = 1'b1;
			c.mem_write = 1'b1;
		end
		c.memtoreg = load;
		c.mem_read = load;
		if (k == KIND_JAL || k == KIND_BLTZAL || k == KIND_BGEZAL) begin
			c.regwrite = 1'b1;
			c.dest_sel = DEST_RA;
			c.link = 1'b1;
		end
		if (k == KIND_JALR) begin
			c.regwrite = 1'b1;
			c.link = 1'b1;
		end
		c.div_mul_en = muldiv;
		c.hilo_read = k == KIND_MFHI || k == KIND_MFLO;
		c.mfhi = k == KIND_MFHI;
		c.mflo = k == KIND_MFLO;
		c.read_rs = two_src || muldiv || store || load || rs_only
			|| (imm_op && k != KIND_LUI) || k == KIND_BEQ || k == KIND_BNE;
		c.read_rt = two_src || by_shamt || muldiv || store || k == KIND_BEQ || k == KIND_BNE;
		case (k)
			KIND_ADD, KIND_ADDI: c.alu_op = ALU_ADD;
			KIND_ADDU, KIND_ADDIU: c.alu_op = ALU_ADDU;
			KIND_SUB: c.alu_op = ALU_SUB;
			KIND_SUBU: c.alu_op = ALU_SUBU;
			KIND_SLT, KIND_SLTI: c.alu_op = ALU_SLT;
			KIND_SLTU, KIND_SLTIU: c.alu_op = ALU_SLTU;
			KIND_AND, KIND_ANDI: c.alu_op = ALU_AND;
			KIND_OR, KIND_ORI: c.alu_op = ALU_OR;
			KIND_XOR, KIND_XORI: c.alu_op = ALU_XOR;
			KIND_NOR: c.alu_op = ALU_NOR;
			KIND_LUI: c.alu_op = ALU_LUI;
			KIND_SLL, KIND_SLLV: c.alu_op = ALU_SLL;
			KIND_SRL, KIND_SRLV: c.alu_op = ALU_SRL;
			KIND_SRA, KIND_SRAV: c.alu_op = ALU_SRA;
			KIND_ROTR, KIND_ROTRV: c.alu_op = ALU_ROTR;
			default: c.alu_op = ALU_NONE;
		endcase
		// memory address is base plus offset
		if (load || store)
			c.alu_op = ALU_ADDU;
		case (k)
			KIND_BEQ: c.branch_cond = BR_EQ;
			KIND_BNE: c.branch_cond = BR_NE;
			KIND_BLEZ: c.branch_cond = BR_LEZ;
			KIND_BGTZ: c.branch_cond = BR_GTZ;
			KIND_BLTZ, KIND_BLTZAL: c.branch_cond = BR_LTZ;
			KIND_BGEZ, KIND_BGEZAL: c.branch_cond = BR_GEZ;
			default: c.branch_cond = BR_NONE;
		endcase
		return c;
	endfunction

	function automatic decoded_t model_decode(logic [31:0] w);
		decoded_t d;
		d.ctrl = model_ctrl(model_kind(w));
		d.wr_reg = 5'd0;
		if (d.ctrl.regwrite) begin
			if (d.ctrl.dest_sel == DEST_RA)
				d.wr_reg = 5'd31;
			else if (d.ctrl.dest_sel == DEST_RT)
				d.wr_reg = w[20:16];
			else
				d.wr_reg = w[15:11];
		end
		d.rs_addr = d.ctrl.read_rs ? w[25:21] : 5'd0;
		d.rt_addr = d.ctrl.read_rt ? w[20:16] : 5'd0;
		d.imm32 = d.ctrl.sign_ex ? {{16{w[15]}}, w[15:0]} : {16'h0000, w[15:0]};
		return d;
	endfunction

	task automatic report_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
		$display("mismatch at %0t ns: %s got 0x%0h expected 0x%0h", $time, sig, got, exp);
		errors++;
	endtask

	task automatic check_valid(logic got, logic exp, string name);
		checks++;
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_ctrl(ctrl_t got, ctrl_t exp, string name);
		checks++;
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_operands(decoded_t got, decoded_t exp, string name);
		checks++;
		if (got.wr_reg !== exp.wr_reg)
			report_mismatch({name, ".wr_reg"}, got.wr_reg, exp.wr_reg);
		if (got.rs_addr !== exp.rs_addr)
			report_mismatch({name, ".rs_addr"}, got.rs_addr, exp.rs_addr);
		if (got.rt_addr !== exp.rt_addr)
			report_mismatch({name, ".rt_addr"}, got.rt_addr, exp.rt_addr);
		if (got.imm32 !== exp.imm32)
			report_mismatch({name, ".imm32"}, got.imm32, exp.imm32);
	endtask

	// stall seen at the negedge applies to the coming edge
	always @(negedge clk) begin
		if (!rst_n) begin
			held = 1'b0;
		end else begin
			if (held) begin
				check_valid(out_valid, held_valid, "out_valid (stalled)");
				if (held_valid) begin
					check_ctrl(dut_out.ctrl, held_out.ctrl, "out.ctrl (stalled)");
					check_operands(dut_out, held_out, "out (stalled)");
				end
			end
			held = stall;
			held_valid = out_valid;
			held_out = dut_out;
			if (out_valid && !stall) begin
				if (expected_q.size() == 0) begin
					$display("error at %0t ns: out_valid is high but no word is pending", $time);
					errors++;
				end else begin
					expected = expected_q.pop_front();
					check_ctrl(dut_out.ctrl, expected.ctrl, "out.ctrl");
					check_operands(dut_out, expected, "out");
				end
			end
		end
	end

	task automatic step_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic drive_word(logic [31:0] w, logic v, logic s);
		in_valid = v;
		stall = s;
		instr = w;
		if (v && !s)
			expected_q.push_back(model_decode(w));
		step_cycle();
	endtask

	task automatic drain();
		int n;
		in_valid = 1'b0;
		stall = 1'b0;
		n = 0;
		while (expected_q.size() != 0 && n < DRAIN_LIMIT) begin
			step_cycle();
			n++;
		end
		if (expected_q.size() != 0) begin
			$display("error at %0t ns: %0d words never came out", $time, expected_q.size());
			errors++;
			expected_q.delete();
		end
		// one idle cycle so a duplicate would show
		step_cycle();
	endtask

	task automatic run_random(int n, int mode, logic use_stall);
		logic [31:0] w;
		logic        v;
		logic        s;
		int          i;
		for (i = 0; i < n; i++) begin
			v = (rand_bits(2) != 0);
			s = use_stall ? (rand_bits(2) == 0) : 1'b0;
			if (mode == MODE_KEPT || (mode == MODE_MIXED && rand_bits(1) == 1))
				w = kept_word();
			else
				w = rand_bits(32);
			drive_word(w, v, s);
		end
	endtask

	task automatic end_test(string name);
		errors += dut_i.instr_decoder_sva_i.failures - assert_failures_seen;
		assert_failures_seen = dut_i.instr_decoder_sva_i.failures;
		$display("test %s: %0d checks, %0d errors", name,
			checks - base_checks, errors - base_errors);
		base_checks = checks;
		base_errors = errors;
	endtask

	task automatic test_reset_latency();
		int lat;
		check_valid(out_valid, 1'b0, "out_valid after reset");
		drive_word(kept_word(), 1'b1, 1'b0);
		in_valid = 1'b0;
		// the accepting edge is the first of the three
		lat = 1;
		while (!out_valid && lat < LATENCY_LIMIT) begin
			step_cycle();
			lat++;
		end
		checks++;
		if (!out_valid) begin
			$display("error at %0t ns: no output within %0d cycles", $time, LATENCY_LIMIT);
			errors++;
		end else if (lat != 3) begin
			report_mismatch("latency", lat, 3);
		end
		drain();
	endtask

	task automatic test_sweep();
		logic [31:0] w;
		int          i;
		int          b;
		for (i = 0; i < N_OPS; i++) begin
			w = rand_bits(32);
			w[31:26] = OP_CODES[i*6 +: 6];
			drive_word(w, 1'b1, 1'b0);
		end
		// each funct once with bits 21 and 6 clear and once with both set
		for (i = 0; i < N_FN; i++) begin
			for (b = 0; b < 2; b++) begin
				w = rand_bits(32);
				w[31:26] = 6'h00;
				w[5:0] = FN_CODES[i*6 +: 6];
				w[21] = b[0];
				w[6] = b[0];
				drive_word(w, 1'b1, 1'b0);
			end
		end
		for (i = 0; i < N_RI; i++) begin
			w = rand_bits(32);
			w[31:26] = 6'h01;
			w[20:16] = RI_CODES[i*5 +: 5];
			drive_word(w, 1'b1, 1'b0);
		end
		drain();
	endtask

	task automatic test_reserved();
		int i;
		for (i = 0; i < N_DROP; i++)
			drive_word(DROPPED[i*32 +: 32], 1'b1, 1'b0);
		run_random(N_RANDOM_RI, MODE_RANDOM, 1'b0);
		drain();
	endtask

	initial begin
		rst_n = 1'b0;
		in_valid = 1'b0;
		stall = 1'b0;
		instr = '0;
		lfsr = 32'h343f_0a8a;
		errors = 0;
		checks = 0;
		base_errors = 0;
		base_checks = 0;
		assert_failures_seen = 0;
		held = 1'b0;
		held_valid = 1'b0;
		held_out = '0;
		expected = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		rst_n = 1'b1;

		test_reset_latency();
		end_test("1 reset and latency");
		test_sweep();
		end_test("2 field decode coverage");
		run_random(N_OPERAND, MODE_KEPT, 1'b0);
		drain();
		end_test("3 operands");
		test_reserved();
		end_test("4 reserved instructions");
		run_random(N_STALL, MODE_MIXED, 1'b1);
		drain();
		end_test("5 stall and throughput");

		$display("5 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD + 400);
		$display("the run timed out before all tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/instr_decoder_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder_sva (
	input wire                  clk,
	input wire                  rst_n,
	input wire                  stall,
	input wire                  out_valid,
	input decode_pkg::decoded_t out
);

	int failures = 0;

	reset_clears_valid: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else begin
			$error("out_valid is high while rst_n is low");
			failures++;
		end

	// a stalled edge leaves the output stage untouched
	stall_holds_valid: assert property (
		@(posedge clk) disable iff (!rst_n) stall |=> $stable(out_valid)
	) else begin
		$error("out_valid changed across a stalled edge");
		failures++;
	end

	stall_holds_payload: assert property (
		@(posedge clk) disable iff (!rst_n) (stall && out_valid) |=> $stable(out)
	) else begin
		$error("out changed across a stalled edge");
		failures++;
	end

	reserved_is_inert: assert property (
		@(posedge clk) disable iff (!rst_n)
		(out_valid && out.ctrl.ri) |->
			(!out.ctrl.regwrite && !out.ctrl.mem_read && !out.ctrl.mem_write)
	) else begin
		$error("reserved instruction enables a write or memory access");
		failures++;
	end

	one_memory_direction: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid |-> !(out.ctrl.mem_read && out.ctrl.mem_write)
	) else begin
		$error("mem_read and mem_write both set");
		failures++;
	end

endmodule

bind instr_decoder instr_decoder_sva instr_decoder_sva_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.stall     (stall),
	.out_valid (out_valid),
	.out       (out)
);

`default_nettype wire

/* src/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  in_valid,
	input  mips_isa_pkg::instr_t instr,
	input  wire                  stall,
	output logic                 out_valid,
	output decode_pkg::decoded_t out
);

	import decode_pkg::*;

	logic        kind_valid;
	kind_stage_t kind_stage;
	logic        ctrl_valid;
	ctrl_stage_t ctrl_stage;

	// word to kind
	kind_decode kind_decode_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.in_valid   (in_valid),
		.instr      (instr),
		.kind_valid (kind_valid),
		.kind_out   (kind_stage)
	);

	// kind to control bundle
	ctrl_gen ctrl_gen_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.kind_valid (kind_valid),
		.kind_in    (kind_stage),
		.ctrl_valid (ctrl_valid),
		.ctrl_out   (ctrl_stage)
	);

	// register numbers and immediate
	operand_resolve operand_resolve_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall      (stall),
		.ctrl_valid (ctrl_valid),
		.ctrl_in    (ctrl_stage),
		.out_valid  (out_valid),
		.out        (out)
	);

endmodule

`default_nettype wire

/* src/operand_resolve.sv */
`timescale 1ns/1ns
`default_nettype none

module operand_resolve (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     stall,
	input  wire                     ctrl_valid,
	input  decode_pkg::ctrl_stage_t ctrl_in,
	output logic                    out_valid,
	output decode_pkg::decoded_t    out
);

	import mips_isa_pkg::*;
	import decode_pkg::*;

	decoded_t    dec;
	logic [15:0] imm16;

	assign imm16 = ctrl_in.instr.i.imm16;

	always_comb begin
		dec.ctrl = ctrl_in.ctrl;

		// no write means register 0, whatever dest_sel says
		dec.wr_reg = '0;
		if (ctrl_in.ctrl.regwrite) begin
			case (ctrl_in.ctrl.dest_sel)
				DEST_RD: dec.wr_reg = ctrl_in.instr.r.rd;
				DEST_RT: dec.wr_reg = ctrl_in.instr.r.rt;
				DEST_RA: dec.wr_reg = REG_RA;
				default: dec.wr_reg = '0;
			endcase
		end

		dec.rs_addr = ctrl_in.ctrl.read_rs ? ctrl_in.instr.r.rs : reg_num_t'(0);
		dec.rt_addr = ctrl_in.ctrl.read_rt ? ctrl_in.instr.r.rt : reg_num_t'(0);

		if (ctrl_in.ctrl.sign_ex) begin
			dec.imm32 = {{16{imm16[15]}}, imm16};
		end else begin
			dec.imm32 = {16'h0000, imm16};
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (!stall) begin
			out_valid <= ctrl_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && ctrl_valid) begin
			out <= dec;
		end
	end

endmodule

`default_nettype wire

/* src/ctrl_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module ctrl_gen (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     stall,
	input  wire                     kind_valid,
	input  decode_pkg::kind_stage_t kind_in,
	output logic                    ctrl_valid,
	output decode_pkg::ctrl_stage_t ctrl_out
);

	import decode_pkg::*;

	alu_op_t      alu_op;
	branch_cond_t br_cond;
	ctrl_t        ctrl;

	always_comb begin
		case (kind_in.kind)
			KIND_ADD, KIND_ADDI:                           alu_op = ALU_ADD;
			KIND_ADDU, KIND_ADDIU:                         alu_op = ALU_ADDU;
			// address generation
			KIND_LW, KIND_LB, KIND_LBU, KIND_LH, KIND_LHU: alu_op = ALU_ADDU;
			KIND_SW, KIND_SB, KIND_SH:                     alu_op = ALU_ADDU;
			KIND_SUB:                                      alu_op = ALU_SUB;
			KIND_SUBU:                                     alu_op = ALU_SUBU;
			KIND_SLT, KIND_SLTI:                           alu_op = ALU_SLT;
			KIND_SLTU, KIND_SLTIU:                         alu_op = ALU_SLTU;
			KIND_AND, KIND_ANDI:                           alu_op = ALU_AND;
			KIND_OR, KIND_ORI:                             alu_op = ALU_OR;
			KIND_XOR, KIND_XORI:                           alu_op = ALU_XOR;
			KIND_NOR:                                      alu_op = ALU_NOR;
			KIND_LUI:                                      alu_op = ALU_LUI;
			KIND_SLL, KIND_SLLV:                           alu_op = ALU_SLL;
			KIND_SRL, KIND_SRLV:                           alu_op = ALU_SRL;
			KIND_SRA, KIND_SRAV:                           alu_op = ALU_SRA;
			KIND_ROTR, KIND_ROTRV:                         alu_op = ALU_ROTR;
			default:                                       alu_op = ALU_NONE;
		endcase
	end

	always_comb begin
		case (kind_in.kind)
			KIND_BEQ:                 br_cond = BR_EQ;
			KIND_BNE:                 br_cond = BR_NE;
			KIND_BLEZ:                br_cond = BR_LEZ;
			KIND_BGTZ:                br_cond = BR_GTZ;
			KIND_BLTZ, KIND_BLTZAL:   br_cond = BR_LTZ;
			KIND_BGEZ, KIND_BGEZAL:   br_cond = BR_GEZ;
			default:                  br_cond = BR_NONE;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.sign_ex = 1'b1;
		ctrl.alu_op = alu_op;
		ctrl.branch_cond = br_cond;
		case (kind_in.kind)
			KIND_ADD, KIND_ADDU, KIND_SUB, KIND_SUBU, KIND_SLT, KIND_SLTU,
			KIND_AND, KIND_OR, KIND_XOR, KIND_NOR,
			KIND_SLLV, KIND_SRLV, KIND_SRAV, KIND_ROTRV, KIND_MOVN, KIND_MOVZ: begin
				{ctrl.regwrite, ctrl.read_rs, ctrl.read_rt} = 3'b111;
			end
			// shift by shamt, rs field is not a source
			KIND_SLL, KIND_SRL, KIND_SRA, KIND_ROTR: begin
				{ctrl.regwrite, ctrl.read_rt} = 2'b11;
			end
			KIND_MFHI: {ctrl.regwrite, ctrl.hilo_read, ctrl.mfhi} = 3'b111;
			KIND_MFLO: {ctrl.regwrite, ctrl.hilo_read, ctrl.mflo} = 3'b111;
			KIND_MTHI, KIND_MTLO, KIND_JR: ctrl.read_rs = 1'b1;
			KIND_MULT, KIND_MULTU, KIND_DIV, KIND_DIVU: begin
				{ctrl.div_mul_en, ctrl.read_rs, ctrl.read_rt} = 3'b111;
			end
			KIND_JALR: {ctrl.regwrite, ctrl.link, ctrl.read_rs} = 3'b111;
			KIND_ADDI, KIND_ADDIU, KIND_SLTI, KIND_SLTIU: begin
				{ctrl.regwrite, ctrl.is_imm, ctrl.read_rs} = 3'b111;
				ctrl.dest_sel = DEST_RT;
			end
			KIND_ANDI, KIND_ORI, KIND_XORI: begin
				{ctrl.regwrite, ctrl.is_imm, ctrl.read_rs} = 3'b111;
				ctrl.dest_sel = DEST_RT;
				ctrl.sign_ex = 1'b0;
			end
			KIND_LUI: begin
				{ctrl.regwrite, ctrl.is_imm} = 2'b11;
				ctrl.dest_sel = DEST_RT;
				ctrl.sign_ex = 1'b0;
			end
			KIND_BEQ, KIND_BNE: {ctrl.read_rs, ctrl.read_rt} = 2'b11;
			KIND_BLEZ, KIND_BGTZ, KIND_BLTZ, KIND_BGEZ: ctrl.read_rs = 1'b1;
			KIND_BLTZAL, KIND_BGEZAL: begin
				{ctrl.regwrite, ctrl.link, ctrl.read_rs} = 3'b111;
				ctrl.dest_sel = DEST_RA;
			end
			KIND_J: ;
			KIND_JAL: begin
				{ctrl.regwrite, ctrl.link} = 2'b11;
				ctrl.dest_sel = DEST_RA;
			end
			KIND_LW, KIND_LB, KIND_LBU, KIND_LH, KIND_LHU: begin
				{ctrl.regwrite, ctrl.is_imm, ctrl.read_rs} = 3'b111;
				{ctrl.memtoreg, ctrl.mem_read} = 2'b11;
				ctrl.dest_sel = DEST_RT;
			end
			KIND_SW, KIND_SB, KIND_SH: begin
				{ctrl.is_imm, ctrl.mem_write} = 2'b11;
				{ctrl.read_rs, ctrl.read_rt} = 2'b11;
			end
			default: begin
				ctrl = '0;
				ctrl.ri = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ctrl_valid <= 1'b0;
		end else if (!stall) begin
			ctrl_valid <= kind_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall && kind_valid) begin
			ctrl_out.instr <= kind_in.instr;
			ctrl_out.ctrl  <= ctrl;
		end
	end

endmodule

`default_nettype wire

/* src/kind_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module kind_decode (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     stall,
	input  wire                     in_valid,
	input  mips_isa_pkg::instr_t    instr,
	output logic                    kind_valid,
	output decode_pkg::kind_stage_t kind_out
);

	import mips_isa_pkg::*;
	import decode_pkg::*;

	inst_kind_t kind;

	always_comb begin
		kind = KIND_RESERVED;
		case (instr.r.op)
			OP_R_TYPE: begin
				case (instr.r.funct)
					FN_ADD:   kind = KIND_ADD;
					FN_ADDU:  kind = KIND_ADDU;
					FN_SUB:   kind = KIND_SUB;
					FN_SUBU:  kind = KIND_SUBU;
					FN_SLT:   kind = KIND_SLT;
					FN_SLTU:  kind = KIND_SLTU;
					FN_AND:   kind = KIND_AND;
					FN_OR:    kind = KIND_OR;
					FN_XOR:   kind = KIND_XOR;
					FN_NOR:   kind = KIND_NOR;
					FN_SLL:   kind = KIND_SLL;
					FN_SRA:   kind = KIND_SRA;
					FN_SLLV:  kind = KIND_SLLV;
					FN_SRAV:  kind = KIND_SRAV;
					// bit 21 turns SRL into ROTR
					FN_SRL:   kind = instr.r.rs[0] ? KIND_ROTR : KIND_SRL;
					// bit 6 turns SRLV into ROTRV
					FN_SRLV:  kind = instr.r.shamt[0] ? KIND_ROTRV : KIND_SRLV;
					FN_MOVN:  kind = KIND_MOVN;
					FN_MOVZ:  kind = KIND_MOVZ;
					FN_MFHI:  kind = KIND_MFHI;
					FN_MFLO:  kind = KIND_MFLO;
					FN_MTHI:  kind = KIND_MTHI;
					FN_MTLO:  kind = KIND_MTLO;
					FN_MULT:  kind = KIND_MULT;
					FN_MULTU: kind = KIND_MULTU;
					FN_DIV:   kind = KIND_DIV;
					FN_DIVU:  kind = KIND_DIVU;
					FN_JR:    kind = KIND_JR;
					FN_JALR:  kind = KIND_JALR;
					default:  kind = KIND_RESERVED;
				endcase
			end
			OP_REGIMM: begin
				case (instr.i.rt)
					RT_BLTZ:   kind = KIND_BLTZ;
					RT_BGEZ:   kind = KIND_BGEZ;
					RT_BLTZAL: kind = KIND_BLTZAL;
					RT_BGEZAL: kind = KIND_BGEZAL;
					default:   kind = KIND_RESERVED;
				endcase
			end
			OP_J:     kind = KIND_J;
			OP_JAL:   kind = KIND_JAL;
			OP_BEQ:   kind = KIND_BEQ;
			OP_BNE:   kind = KIND_BNE;
			OP_BLEZ:  kind = KIND_BLEZ;
			OP_BGTZ:  kind = KIND_BGTZ;
			OP_ADDI:  kind = KIND_ADDI;
			OP_ADDIU: kind = KIND_ADDIU;
			OP_SLTI:  kind = KIND_SLTI;
			OP_SLTIU: kind = KIND_SLTIU;
			OP_ANDI:  kind = KIND_ANDI;
			OP_ORI:   kind = KIND_ORI;
			OP_XORI:  kind = KIND_XORI;
			OP_LUI:   kind = KIND_LUI;
			OP_LW:    kind = KIND_LW;
			OP_LB:    kind = KIND_LB;
			OP_LBU:   kind = KIND_LBU;
			OP_LH:    kind = KIND_LH;
			OP_LHU:   kind = KIND_LHU;
			OP_SW:    kind = KIND_SW;
			OP_SB:    kind = KIND_SB;
			OP_SH:    kind = KIND_SH;
			default:  kind = KIND_RESERVED;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			kind_valid <= 1'b0;
		end else if (!stall) begin
			kind_valid <= in_valid;
		end
	end

	// payload only loads on an accepted word
	always_ff @(posedge clk) begin
		if (!stall && in_valid) begin
			kind_out.instr <= instr;
			kind_out.kind  <= kind;
		end
	end

endmodule

`default_nettype wire

/* src/decode_pkg.sv */
`default_nettype none

package decode_pkg;

	import mips_isa_pkg::*;

	typedef enum logic [5:0] {
		KIND_RESERVED,
		KIND_ADD, KIND_ADDU, KIND_SUB, KIND_SUBU, KIND_SLT, KIND_SLTU,
		KIND_AND, KIND_OR, KIND_XOR, KIND_NOR,
		KIND_SLL, KIND_SRL, KIND_SRA, KIND_ROTR,
		KIND_SLLV, KIND_SRLV, KIND_SRAV, KIND_ROTRV,
		KIND_MOVN, KIND_MOVZ,
		KIND_MFHI, KIND_MFLO, KIND_MTHI, KIND_MTLO,
		KIND_MULT, KIND_MULTU, KIND_DIV, KIND_DIVU,
		KIND_JR, KIND_JALR,
		KIND_ADDI, KIND_ADDIU, KIND_SLTI, KIND_SLTIU,
		KIND_ANDI, KIND_ORI, KIND_XORI, KIND_LUI,
		KIND_BEQ, KIND_BNE, KIND_BLEZ, KIND_BGTZ,
		KIND_BLTZ, KIND_BGEZ, KIND_BLTZAL, KIND_BGEZAL,
		KIND_J, KIND_JAL,
		KIND_LW, KIND_LB, KIND_LBU, KIND_LH, KIND_LHU,
		KIND_SW, KIND_SB, KIND_SH
	} inst_kind_t;

	// ALU_NONE is zero so a reserved word has an all-clear bundle
	typedef enum logic [3:0] {
		ALU_NONE, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_ROTR
	} alu_op_t;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ
	} branch_cond_t;

	typedef enum logic [1:0] {
		DEST_RD, DEST_RT, DEST_RA
	} dest_sel_t;

	typedef struct packed {
		logic         regwrite;
		logic         is_imm;
		logic         sign_ex;
		logic         memtoreg;
		logic         mem_read;
		logic         mem_write;
		logic         read_rs;
		logic         read_rt;
		logic         hilo_read;
		logic         mfhi;
		logic         mflo;
		logic         div_mul_en;
		logic         link;
		logic         ri;
		dest_sel_t    dest_sel;
		alu_op_t      alu_op;
		branch_cond_t branch_cond;
	} ctrl_t;

	typedef struct packed {
		instr_t     instr;
		inst_kind_t kind;
	} kind_stage_t;

	typedef struct packed {
		instr_t instr;
		ctrl_t  ctrl;
	} ctrl_stage_t;

	typedef struct packed {
		ctrl_t       ctrl;
		reg_num_t    wr_reg;
		reg_num_t    rs_addr;
		reg_num_t    rt_addr;
		logic [31:0] imm32;
	} decoded_t;

endpackage

`default_nettype wire

/* src/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

	// major opcode, bits 31:26
	typedef enum logic [5:0] {
		OP_R_TYPE = 6'h00,
		OP_REGIMM = 6'h01,
		OP_J      = 6'h02,
		OP_JAL    = 6'h03,
		OP_BEQ    = 6'h04,
		OP_BNE    = 6'h05,
		OP_BLEZ   = 6'h06,
		OP_BGTZ   = 6'h07,
		OP_ADDI   = 6'h08,
		OP_ADDIU  = 6'h09,
		OP_SLTI   = 6'h0a,
		OP_SLTIU  = 6'h0b,
		OP_ANDI   = 6'h0c,
		OP_ORI    = 6'h0d,
		OP_XORI   = 6'h0e,
		OP_LUI    = 6'h0f,
		OP_LB     = 6'h20,
		OP_LH     = 6'h21,
		OP_LW     = 6'h23,
		OP_LBU    = 6'h24,
		OP_LHU    = 6'h25,
		OP_SB     = 6'h28,
		OP_SH     = 6'h29,
		OP_SW     = 6'h2b
	} opcode_t;

	// funct field of R_TYPE, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL   = 6'h00,
		FN_SRL   = 6'h02,
		FN_SRA   = 6'h03,
		FN_SLLV  = 6'h04,
		FN_SRLV  = 6'h06,
		FN_SRAV  = 6'h07,
		FN_JR    = 6'h08,
		FN_JALR  = 6'h09,
		FN_MOVZ  = 6'h0a,
		FN_MOVN  = 6'h0b,
		FN_MFHI  = 6'h10,
		FN_MTHI  = 6'h11,
		FN_MFLO  = 6'h12,
		FN_MTLO  = 6'h13,
		FN_MULT  = 6'h18,
		FN_MULTU = 6'h19,
		FN_DIV   = 6'h1a,
		FN_DIVU  = 6'h1b,
		FN_ADD   = 6'h20,
		FN_ADDU  = 6'h21,
		FN_SUB   = 6'h22,
		FN_SUBU  = 6'h23,
		FN_AND   = 6'h24,
		FN_OR    = 6'h25,
		FN_XOR   = 6'h26,
		FN_NOR   = 6'h27,
		FN_SLT   = 6'h2a,
		FN_SLTU  = 6'h2b
	} funct_t;

	// rt field of REGIMM
	typedef enum logic [4:0] {
		RT_BLTZ   = 5'h00,
		RT_BGEZ   = 5'h01,
		RT_BLTZAL = 5'h10,
		RT_BGEZAL = 5'h11
	} regimm_t;

	typedef logic [4:0] reg_num_t;

	localparam reg_num_t REG_RA = 5'd31;

	typedef struct packed {
		opcode_t    op;
		reg_num_t   rs;
		reg_num_t   rt;
		reg_num_t   rd;
		logic [4:0] shamt;
		funct_t     funct;
	} r_view_t;

	typedef struct packed {
		opcode_t     op;
		reg_num_t    rs;
		reg_num_t    rt;
		logic [15:0] imm16;
	} i_view_t;

	typedef struct packed {
		opcode_t     op;
		logic [25:0] target26;
	} j_view_t;

	// one word, three field layouts
	typedef union packed {
		r_view_t r;
		i_view_t i;
		j_view_t j;
	} instr_t;

endpackage

`default_nettype wire
